// File: src.f
+incdir+hw
hw/fifo_pkg.sv
hw/fifo_occupancy.sv
hw/fifo_addr_gen.sv
hw/fifo_strobes.sv
hw/fifo_ram.sv
hw/sync_fifo.sv
tests/fifo_assertions.sv
tests/fifo_checker.sv
tests/tb_sync_fifo.sv

// File: tests/tb_sync_fifo.sv
/* testbench top for sync_fifo; random phases from a fixed xorshift seed,
   all comparing done in fifo_checker, sizes from the settings header */
`timescale 1ns/1ns
`include "fifo_settings.svh"

module tb_sync_fifo;

   localparam int RESET_CYCLES = 8;
   localparam int DRIVE_DELAY  = 2;                 // ns after the rising edge
   localparam int WAIT_LIMIT   = 20 * `FIFO_DEPTH;  // cycles per level wait

   logic                  pos_clk;
   logic                  aresetn;
   logic                  wr_en;
   logic                  rd_en;
   fifo_pkg::fifo_data_t  wr_data;
   fifo_pkg::fifo_data_t  rd_data;
   logic                  full;
   logic                  afull;
   logic                  empty;
   logic                  aempty;
   fifo_pkg::fifo_count_t wrcnt;
   logic                  wack;
   logic                  dvld;
   logic                  overflow;
   logic                  underflow;
   logic [31:0]           rng_state;
   bit                    timed_out;
   int                    error_count;
   int                    check_count;
   int                    overflow_count;
   int                    underflow_count;

   always #10 pos_clk = ~pos_clk;  // 20 ns period

   sync_fifo i_dut (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_en_i     (wr_en),
      .wr_data_i   (wr_data),
      .rd_en_i     (rd_en),
      .rd_data_o   (rd_data),
      .full_o      (full),
      .afull_o     (afull),
      .empty_o     (empty),
      .aempty_o    (aempty),
      .wrcnt_o     (wrcnt),
      .wack_o      (wack),
      .dvld_o      (dvld),
      .overflow_o  (overflow),
      .underflow_o (underflow)
   );

   fifo_checker i_checker (
      .pos_clk           (pos_clk),
      .aresetn           (aresetn),
      .wr_en_i           (wr_en),
      .wr_data_i         (wr_data),
      .rd_en_i           (rd_en),
      .rd_data_i         (rd_data),
      .full_i            (full),
      .afull_i           (afull),
      .empty_i           (empty),
      .aempty_i          (aempty),
      .wrcnt_i           (wrcnt),
      .wack_i            (wack),
      .dvld_i            (dvld),
      .overflow_i        (overflow),
      .underflow_i       (underflow),
      .error_count_o     (error_count),
      .check_count_o     (check_count),
      .overflow_count_o  (overflow_count),
      .underflow_count_o (underflow_count)
   );

   // ------------------------------------------------------------------------
   // stimulus helpers
   // ------------------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // one cycle of random requests, percent chance per enable
   task automatic drive_cycle(input int wr_pct, input int rd_pct);
      @(posedge pos_clk);
      #DRIVE_DELAY;
      rng_state = xorshift32(rng_state);
      wr_en     = (rng_state % 100) < wr_pct;
      rng_state = xorshift32(rng_state);
      rd_en     = (rng_state % 100) < rd_pct;
      rng_state = xorshift32(rng_state);
      wr_data   = fifo_pkg::fifo_data_t'(rng_state);
   endtask

   task automatic run_cycles(input int n, input int wr_pct, input int rd_pct);
      repeat (n) drive_cycle(wr_pct, rd_pct);
   endtask

   // keeps driving until full (or empty), gives up after WAIT_LIMIT cycles
   task automatic run_until(input int wr_pct, input int rd_pct, input bit want_full,
                            input string what);
      int n;
      n = 0;
      while (!(want_full ? full : empty) && n < WAIT_LIMIT) begin
         drive_cycle(wr_pct, rd_pct);
         n++;
      end
      if (!(want_full ? full : empty)) begin
         $display("timeout: FIFO did not become %s within %0d cycles", what, WAIT_LIMIT);
         timed_out = 1'b1;
      end
   endtask

   task automatic end_run();
      int assert_fails;
      assert_fails = i_dut.i_assertions.fail_count;  // bound checker instance
      $display("checks %0d, errors %0d, assertion failures %0d, overflows %0d, underflows %0d",
               check_count, error_count, assert_fails, overflow_count, underflow_count);
      if (timed_out || error_count != 0 || assert_fails != 0) begin
         $display("Test FAILED");
      end else begin
         $display("Test OK");
      end
      $finish;
   endtask

   // ------------------------------------------------------------------------
   // phases
   // ------------------------------------------------------------------------
   initial begin
      pos_clk   = 1'b0;
      aresetn   = 1'b0;
      wr_en     = 1'b0;
      rd_en     = 1'b0;
      wr_data   = '0;
      rng_state = 32'h68d2_2111;
      timed_out = 1'b0;
      repeat (RESET_CYCLES) @(posedge pos_clk);
      #DRIVE_DELAY;
      aresetn = 1'b1;
      run_until(90, 10, 1'b1, "full");                // fill up
      if (!timed_out) run_cycles(40, 80, 20);         // push into overflow
      if (!timed_out) run_until(10, 90, 1'b0, "empty");
      if (!timed_out) run_cycles(40, 15, 85);         // underflows
      if (!timed_out) run_cycles(400, 50, 50);        // balanced, wraps a lot
      if (!timed_out) run_until(0, 100, 1'b0, "empty");
      if (!timed_out) run_cycles(3, 0, 0);            // let last strobes be checked
      end_run();
   end

endmodule

// File: tests/fifo_checker.sv
/* queue model of the FIFO, compared with the DUT ports at every falling edge;
   inputs are expected to change only after the rising edge */
`timescale 1ns/1ns
`include "fifo_settings.svh"

module fifo_checker (
   input  logic                  pos_clk,
   input  logic                  aresetn,
   input  logic                  wr_en_i,
   input  fifo_pkg::fifo_data_t  wr_data_i,
   input  logic                  rd_en_i,
   input  fifo_pkg::fifo_data_t  rd_data_i,
   input  logic                  full_i,
   input  logic                  afull_i,
   input  logic                  empty_i,
   input  logic                  aempty_i,
   input  fifo_pkg::fifo_count_t wrcnt_i,
   input  logic                  wack_i,
   input  logic                  dvld_i,
   input  logic                  overflow_i,
   input  logic                  underflow_i,
   output int                    error_count_o,
   output int                    check_count_o,
   output int                    overflow_count_o,
   output int                    underflow_count_o
);

   fifo_pkg::fifo_data_t model_q[$];  // oldest entry at the front
   fifo_pkg::fifo_data_t exp_rdata;
   bit                   rdata_known; // false until the first read
   bit                   exp_wack;
   bit                   exp_dvld;
   bit                   exp_ovf;
   bit                   exp_unf;

   initial begin
      error_count_o     = 0;
      check_count_o     = 0;
      overflow_count_o  = 0;
      underflow_count_o = 0;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      check_count_o++;
      if (got !== exp) begin
         error_count_o++;
         $display("error %s: got %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // ------------------------------------------------------------------------
   // outputs against the model state of the last edge
   // ------------------------------------------------------------------------
   task automatic compare_outputs();
      int cnt;
      cnt = model_q.size();
      check_value("wrcnt_o", wrcnt_i, cnt);
      check_value("full_o", full_i, cnt == `FIFO_DEPTH);
      check_value("afull_o", afull_i, cnt >= `FIFO_AFULL_VAL);
      check_value("empty_o", empty_i, cnt == 0);
      check_value("aempty_o", aempty_i, cnt <= `FIFO_AEMPTY_VAL);
      check_value("wack_o", wack_i, exp_wack);
      check_value("dvld_o", dvld_i, exp_dvld);
      check_value("overflow_o", overflow_i, exp_ovf);
      check_value("underflow_o", underflow_i, exp_unf);
      if (rdata_known) begin
         check_value("rd_data_o", rd_data_i, exp_rdata);  // also holds between reads
      end
   endtask

   // ------------------------------------------------------------------------
   // effect of the coming rising edge
   // ------------------------------------------------------------------------
   task automatic step_model();
      bit wr_acc;
      bit rd_acc;
      wr_acc   = wr_en_i && (model_q.size() != `FIFO_DEPTH);
      rd_acc   = rd_en_i && (model_q.size() != 0);  // flags before the edge
      exp_wack = wr_acc;
      exp_dvld = rd_acc;
      exp_ovf  = wr_en_i && !wr_acc;
      exp_unf  = rd_en_i && !rd_acc;
      if (exp_ovf) overflow_count_o++;
      if (exp_unf) underflow_count_o++;
      if (rd_acc) begin
         exp_rdata   = model_q.pop_front();  // pop first, write+read on nonempty
         rdata_known = 1'b1;
      end
      if (wr_acc) model_q.push_back(wr_data_i);
   endtask

   always @(negedge pos_clk) begin
      if (!aresetn) begin
         model_q.delete();
         rdata_known = 1'b0;
         exp_wack    = 1'b0;
         exp_dvld    = 1'b0;
         exp_ovf     = 1'b0;
         exp_unf     = 1'b0;
         compare_outputs();  // reset values
      end else begin
         compare_outputs();
         step_model();
      end
   end

endmodule

// File: tests/fifo_assertions.sv
/* flag consistency rules of sync_fifo, bound into every sync_fifo instance;
   off while aresetn is low */
`timescale 1ns/1ns
`include "fifo_settings.svh"

module fifo_assertions (
   input logic                  pos_clk,
   input logic                  aresetn,
   input logic                  full_i,
   input logic                  afull_i,
   input logic                  empty_i,
   input logic                  aempty_i,
   input fifo_pkg::fifo_count_t wrcnt_i
);

   int fail_count = 0;  // read by the testbench top

   // ------------------------------------------------------------------------
   // flag rules
   // ------------------------------------------------------------------------
   a_not_full_and_empty: assert property (@(posedge pos_clk) disable iff (!aresetn)
      !(full_i && empty_i))
      else begin
         fail_count++;
         $error("full and empty are both high");
      end

   a_count_in_range: assert property (@(posedge pos_clk) disable iff (!aresetn)
      wrcnt_i <= `FIFO_DEPTH)
      else begin
         fail_count++;
         $error("occupancy count is above the FIFO depth");
      end

   a_full_afull: assert property (@(posedge pos_clk) disable iff (!aresetn)
      full_i |-> afull_i)
      else begin
         fail_count++;
         $error("full is high without almost-full");
      end

   a_empty_aempty: assert property (@(posedge pos_clk) disable iff (!aresetn)
      empty_i |-> aempty_i)
      else begin
         fail_count++;
         $error("empty is high without almost-empty");
      end

endmodule

bind sync_fifo fifo_assertions i_assertions (
   .pos_clk  (pos_clk),
   .aresetn  (aresetn),
   .full_i   (full_o),
   .afull_i  (afull_o),
   .empty_i  (empty_o),
   .aempty_i (aempty_o),
   .wrcnt_i  (wrcnt_o)
);

// File: hw/sync_fifo.sv
/* single-clock FIFO top, sizes from the settings header; refused requests
   are dropped and reported on overflow_o and underflow_o, never retried */
`timescale 1ns/1ns

module sync_fifo (
   input  logic                  pos_clk,
   input  logic                  aresetn,
   input  logic                  wr_en_i,
   input  fifo_pkg::fifo_data_t  wr_data_i,
   input  logic                  rd_en_i,
   output fifo_pkg::fifo_data_t  rd_data_o,
   output logic                  full_o,
   output logic                  afull_o,
   output logic                  empty_o,
   output logic                  aempty_o,
   output fifo_pkg::fifo_count_t wrcnt_o,
   output logic                  wack_o,
   output logic                  dvld_o,
   output logic                  overflow_o,
   output logic                  underflow_o
);

   logic                 wr_accept;   // gated write
   logic                 rd_accept;   // gated read
   fifo_pkg::fifo_addr_t waddr;
   fifo_pkg::fifo_addr_t raddr;

   // ------------------------------------------------------------------------
   // control
   // ------------------------------------------------------------------------
   fifo_occupancy i_occupancy (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_en_i     (wr_en_i),
      .rd_en_i     (rd_en_i),
      .wr_accept_o (wr_accept),
      .rd_accept_o (rd_accept),
      .count_o     (wrcnt_o),
      .full_o      (full_o),
      .afull_o     (afull_o),
      .empty_o     (empty_o),
      .aempty_o    (aempty_o)
   );

   fifo_addr_gen i_addr_gen (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_accept_i (wr_accept),
      .rd_accept_i (rd_accept),
      .waddr_o     (waddr),
      .raddr_o     (raddr)
   );

   fifo_strobes i_strobes (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_en_i     (wr_en_i),
      .rd_en_i     (rd_en_i),
      .wr_accept_i (wr_accept),
      .rd_accept_i (rd_accept),
      .wack_o      (wack_o),
      .dvld_o      (dvld_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o)
   );

   // ------------------------------------------------------------------------
   // storage
   // ------------------------------------------------------------------------
   fifo_ram i_ram (
      .pos_clk (pos_clk),
      .we_i    (wr_accept),
      .waddr_i (waddr),
      .wdata_i (wr_data_i),
      .re_i    (rd_accept),
      .raddr_i (raddr),
      .rdata_o (rd_data_o)   // valid with dvld_o
   );

endmodule

// File: hw/fifo_ram.sv
/* FIFO_DEPTH x FIFO_DATA_W storage, synchronous write, registered read;
   the read word holds between reads and is undefined until the first one */
`timescale 1ns/1ns
`include "fifo_settings.svh"

module fifo_ram (
   input  logic                 pos_clk,
   input  logic                 we_i,     // write strobe, already gated
   input  fifo_pkg::fifo_addr_t waddr_i,
   input  fifo_pkg::fifo_data_t wdata_i,
   input  logic                 re_i,     // read strobe, already gated
   input  fifo_pkg::fifo_addr_t raddr_i,
   output fifo_pkg::fifo_data_t rdata_o
);

   fifo_pkg::fifo_data_t mem [`FIFO_DEPTH]; // storage array
   fifo_pkg::fifo_data_t rdata_q;           // read data register

   // ------------------------------------------------------------------------
   // write port
   // ------------------------------------------------------------------------
   always_ff @(posedge pos_clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // read port, data one cycle after re_i
   // pointers never meet on an accepted read, so no bypass is needed
   always_ff @(posedge pos_clk) begin
      if (re_i) begin
         rdata_q <= mem[raddr_i];
      end
   end

   assign rdata_o = rdata_q;

endmodule

// File: hw/fifo_strobes.sv
/* one-cycle status strobes, each one cycle after its event; a request that is
   present but not accepted counts as refused */
`timescale 1ns/1ns

module fifo_strobes (
   input  logic pos_clk,
   input  logic aresetn,
   input  logic wr_en_i,      // raw write request
   input  logic rd_en_i,      // raw read request
   input  logic wr_accept_i,
   input  logic rd_accept_i,
   output logic wack_o,       // write acknowledge
   output logic dvld_o,       // read data valid
   output logic overflow_o,   // write refused
   output logic underflow_o   // read refused
);

   logic wack_q;
   logic dvld_q;
   logic overflow_q;
   logic underflow_q;

   // ------------------------------------------------------------------------
   // strobe registers
   // ------------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_q      <= 1'b0;
         dvld_q      <= 1'b0;
         overflow_q  <= 1'b0;
         underflow_q <= 1'b0;
      end else begin
         wack_q      <= wr_accept_i;
         dvld_q      <= rd_accept_i;             // lines up with the RAM read
         overflow_q  <= wr_en_i & ~wr_accept_i;  // asked while full
         underflow_q <= rd_en_i & ~rd_accept_i;  // asked while empty
      end
   end

   assign wack_o      = wack_q;
   assign dvld_o      = dvld_q;
   assign overflow_o  = overflow_q;
   assign underflow_o = underflow_q;

endmodule

// File: hw/fifo_addr_gen.sv
/* write and read pointers of the storage; both wrap from FIFO_DEPTH-1 to 0,
   so the depth need not be a power of two */
`timescale 1ns/1ns
`include "fifo_settings.svh"

module fifo_addr_gen (
   input  logic                 pos_clk,
   input  logic                 aresetn,
   input  logic                 wr_accept_i, // advance write pointer
   input  logic                 rd_accept_i, // advance read pointer
   output fifo_pkg::fifo_addr_t waddr_o,
   output fifo_pkg::fifo_addr_t raddr_o
);

   fifo_pkg::fifo_addr_t waddr_q;
   fifo_pkg::fifo_addr_t raddr_q;

   // ------------------------------------------------------------------------
   // pointer counters
   // ------------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         waddr_q <= '0;
         raddr_q <= '0;
      end else begin
         if (wr_accept_i) begin
            if (waddr_q == fifo_pkg::fifo_addr_t'(`FIFO_DEPTH - 1)) begin
               waddr_q <= '0;             // last entry, wrap
            end else begin
               waddr_q <= waddr_q + 1'b1;
            end
         end
         if (rd_accept_i) begin
            if (raddr_q == fifo_pkg::fifo_addr_t'(`FIFO_DEPTH - 1)) begin
               raddr_q <= '0;
            end else begin
               raddr_q <= raddr_q + 1'b1;
            end
         end
      end
   end

   assign waddr_o = waddr_q;  // address of the next free slot
   assign raddr_o = raddr_q;  // address of the oldest entry

endmodule

// File: hw/fifo_occupancy.sv
/* occupancy counter and level flags; requests are gated by the registered flags,
   so a write into a full FIFO or a read from an empty one is dropped */
`timescale 1ns/1ns
`include "fifo_settings.svh"

module fifo_occupancy (
   input  logic                  pos_clk,
   input  logic                  aresetn,
   input  logic                  wr_en_i,     // raw write request
   input  logic                  rd_en_i,     // raw read request
   output logic                  wr_accept_o, // write taken this cycle
   output logic                  rd_accept_o, // read taken this cycle
   output fifo_pkg::fifo_count_t count_o,
   output logic                  full_o,
   output logic                  afull_o,
   output logic                  empty_o,
   output logic                  aempty_o
);

   fifo_pkg::fifo_count_t count_q;    // entries held
   fifo_pkg::fifo_count_t count_next; // value after this edge
   logic                  full_q;
   logic                  afull_q;
   logic                  empty_q;
   logic                  aempty_q;

   // ------------------------------------------------------------------------
   // request gating
   // ------------------------------------------------------------------------
   // only place in the design that looks at full and empty
   assign wr_accept_o = wr_en_i & ~full_q;
   assign rd_accept_o = rd_en_i & ~empty_q;

   // ------------------------------------------------------------------------
   // next count
   // ------------------------------------------------------------------------
   always_comb begin
      count_next = count_q;                      // hold, also on write+read
      if (wr_accept_o && !rd_accept_o) begin
         count_next = count_q + 1'b1;            // write alone
      end else if (rd_accept_o && !wr_accept_o) begin
         count_next = count_q - 1'b1;            // read alone
      end
   end

   // ------------------------------------------------------------------------
   // count and level flags
   // ------------------------------------------------------------------------
   // flags come from count_next so they move on the same edge as the count
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         count_q  <= '0;
         full_q   <= 1'b0;
         afull_q  <= 1'b0;
         empty_q  <= 1'b1;   // starts empty
         aempty_q <= 1'b1;
      end else begin
         count_q  <= count_next;
         full_q   <= (count_next == fifo_pkg::fifo_count_t'(`FIFO_DEPTH));
         afull_q  <= (count_next >= fifo_pkg::fifo_count_t'(`FIFO_AFULL_VAL));
         empty_q  <= (count_next == '0);
         aempty_q <= (count_next <= fifo_pkg::fifo_count_t'(`FIFO_AEMPTY_VAL));
      end
   end

   // ------------------------------------------------------------------------
   // outputs
   // ------------------------------------------------------------------------
   assign count_o  = count_q;
   assign full_o   = full_q;
   assign afull_o  = afull_q;
   assign empty_o  = empty_q;
   assign aempty_o = aempty_q;

endmodule

// File: hw/fifo_pkg.sv
/* shared types of the sync FIFO, widths taken from the settings header */
`include "fifo_settings.svh"

package fifo_pkg;

   // one stored word
   typedef logic [`FIFO_DATA_W-1:0] fifo_data_t;

   // memory address, counts 0 .. FIFO_DEPTH-1
   typedef logic [`FIFO_ADDR_W-1:0] fifo_addr_t;

   // occupancy 0 .. FIFO_DEPTH, one bit wider than the address
   typedef logic [`FIFO_ADDR_W:0] fifo_count_t;

endpackage

// File: hw/fifo_settings.svh
/* sizes and flag thresholds of the sync FIFO; FIFO_DEPTH-1 must fit in FIFO_ADDR_W bits
   and both thresholds must lie between 0 and FIFO_DEPTH */
`ifndef FIFO_SETTINGS_SVH
`define FIFO_SETTINGS_SVH

// ---------------------------------------------------------------------------
// storage geometry
// ---------------------------------------------------------------------------
`define FIFO_DATA_W     18 // bits per entry
`define FIFO_DEPTH      12 // entries, any value, not only powers of two
`define FIFO_ADDR_W     4  // enough bits for FIFO_DEPTH-1

// ---------------------------------------------------------------------------
// static flag thresholds, compared against the occupancy count
// ---------------------------------------------------------------------------
// almost-full once the count reaches this value
`define FIFO_AFULL_VAL  9
// almost-empty while the count is at or below this value
`define FIFO_AEMPTY_VAL 3

`endif
